//--- logic/spi_link_pkg.sv
`default_nettype none

package spi_link_pkg;

	typedef logic [31:0] frame_t; // Host and buffer data
	typedef logic [7:0] spi_word_t; // One SPI byte

	localparam int FRAME_BYTES = $bits(frame_t) / $bits(spi_word_t);

	// Frame buffer status
	typedef struct packed {
		logic has_data; // Unread frames remain
		logic empty; // Nothing written since last clear
		logic drained; // Everything written was read
		logic full; // Write count at depth
	} buf_flags_t;

	// Frame serializer FSM
	typedef enum logic [2:0] {
		s_idle,
		s_fetch, // Issue next byte
		s_shift, // Wait for byte done
		s_store, // Push received frame
		s_release // Chip select gap
	} serdes_state_t;

endpackage

`default_nettype wire

//--- logic/frame_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module frame_buffer #(
	parameter int BUF_DEPTH = 8
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      clear,
	input  logic                      wr,
	input  spi_link_pkg::frame_t      data_in,
	input  logic                      oe,
	output spi_link_pkg::frame_t      data_out,
	output spi_link_pkg::buf_flags_t  flags
);

	localparam int AW = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
	localparam int CW = $clog2(BUF_DEPTH + 1); // Counts up to BUF_DEPTH

	spi_link_pkg::frame_t mem [BUF_DEPTH];

	logic [CW-1:0] wr_ptr;
	logic [CW-1:0] rd_ptr;
	logic [CW-1:0] wr_ptr_next;
	logic [CW-1:0] rd_ptr_next;
	logic do_wr;
	logic do_rd;
	spi_link_pkg::buf_flags_t flags_next;

	assign do_wr = wr && !flags.full;
	assign do_rd = oe && flags.has_data;

	// Pointer and flag lookahead
	always_comb begin
		if (clear) begin
			wr_ptr_next = '0;
			rd_ptr_next = '0;
		end else begin
			wr_ptr_next = wr_ptr + CW'(do_wr);
			rd_ptr_next = rd_ptr + CW'(do_rd);
		end

		flags_next.has_data = rd_ptr_next != wr_ptr_next;
		flags_next.empty = wr_ptr_next == '0;
		flags_next.drained = (wr_ptr_next != '0) && (rd_ptr_next == wr_ptr_next);
		flags_next.full = wr_ptr_next == CW'(BUF_DEPTH);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			flags <= '{has_data: 1'b0, empty: 1'b1, drained: 1'b0, full: 1'b0};
		end else begin
			wr_ptr <= wr_ptr_next;
			rd_ptr <= rd_ptr_next;
			flags <= flags_next;
		end
	end

	// Storage and read port
	always_ff @(posedge clk) begin
		if (do_wr && !clear) begin
			mem[wr_ptr[AW-1:0]] <= data_in;
		end
		if (do_rd && !clear) begin
			data_out <= mem[rd_ptr[AW-1:0]]; // Valid the cycle after oe
		end
	end

endmodule

`default_nettype wire

//--- logic/buffer_switch.sv
`timescale 1ns/1ns
`default_nettype none

module buffer_switch #(
	parameter int BUF_DEPTH = 8
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      wr,
	input  spi_link_pkg::frame_t      data_in,
	input  logic                      send,
	output spi_link_pkg::buf_flags_t  tx_flags,
	output logic                      frame_req,
	input  logic                      frame_ack,
	output spi_link_pkg::frame_t      tx_frame
);

	// Producer side of the frame handoff
	typedef enum logic [1:0] {
		hs_idle,
		hs_load, // Drain data_out being loaded
		hs_req, // Waiting for ack
		hs_wait // Waiting for ack to drop
	} hs_state_t;

	hs_state_t hs_state;
	logic sel; // Index of the fill buffer
	logic send_seen;
	logic swap;
	logic drain_rd;

	logic [1:0] buf_wr;
	logic [1:0] buf_oe;
	logic [1:0] buf_clear;
	spi_link_pkg::buf_flags_t buf_flags [2];
	spi_link_pkg::frame_t buf_dout [2];
	spi_link_pkg::buf_flags_t fill_flags;
	spi_link_pkg::buf_flags_t drain_flags;

	assign fill_flags = buf_flags[sel];
	assign drain_flags = buf_flags[!sel];
	assign tx_flags = fill_flags;
	assign tx_frame = buf_dout[!sel];

	// Fetch the next frame only between handoffs
	assign drain_rd = (hs_state == hs_idle) && drain_flags.has_data;

	assign swap = (drain_flags.empty || drain_flags.drained)
		&& (hs_state == hs_idle)
		&& fill_flags.has_data
		&& (send_seen || send || fill_flags.full);

	for (genvar i = 0; i < 2; i++) begin : g_buf
		assign buf_wr[i] = wr && (sel == 1'(i));
		assign buf_oe[i] = drain_rd && (sel != 1'(i));
		assign buf_clear[i] = swap && (sel != 1'(i)); // Old drain side

		frame_buffer #(
			.BUF_DEPTH(BUF_DEPTH)
		) u_buf (
			.clk(clk),
			.rst(rst),
			.clear(buf_clear[i]),
			.wr(buf_wr[i]),
			.data_in(data_in),
			.oe(buf_oe[i]),
			.data_out(buf_dout[i]),
			.flags(buf_flags[i])
		);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sel <= 1'b0;
			send_seen <= 1'b0;
		end else if (swap) begin
			sel <= !sel;
			send_seen <= 1'b0;
		end else if (send) begin
			send_seen <= 1'b1; // Held until the swap goes through
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hs_state <= hs_idle;
			frame_req <= 1'b0;
		end else begin
			case (hs_state)
				hs_idle: begin
					if (drain_rd) begin
						hs_state <= hs_load;
					end
				end
				hs_load: begin
					frame_req <= 1'b1; // tx_frame stable from here
					hs_state <= hs_req;
				end
				hs_req: begin
					if (frame_ack) begin
						frame_req <= 1'b0;
						hs_state <= hs_wait;
					end
				end
				hs_wait: begin
					if (!frame_ack) begin
						hs_state <= hs_idle;
					end
				end
				default: hs_state <= hs_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/frame_serdes.sv
`timescale 1ns/1ns
`default_nettype none

module frame_serdes #(
	parameter int CLK_DIV = 2
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    frame_req,
	output logic                    frame_ack,
	input  spi_link_pkg::frame_t    tx_frame,
	output logic                    start,
	output spi_link_pkg::spi_word_t tx_byte,
	input  logic                    busy,
	input  logic                    done,
	input  spi_link_pkg::spi_word_t rx_byte,
	output logic                    rx_wr,
	output spi_link_pkg::frame_t    rx_frame,
	input  logic                    rx_full,
	output logic                    rx_overflow,
	output logic                    cs_n
);

	localparam int WB = $bits(spi_link_pkg::spi_word_t);
	localparam int FB = $bits(spi_link_pkg::frame_t);
	localparam int BCW = $clog2(spi_link_pkg::FRAME_BYTES);
	localparam int GAP = 2 * CLK_DIV; // Minimum cs_n high time
	localparam int GW = $clog2(GAP + 1);

	spi_link_pkg::serdes_state_t state;
	spi_link_pkg::frame_t tx_sr;
	logic [BCW-1:0] byte_cnt;
	logic [GW-1:0] gap_cnt;
	logic accept;
	logic last_byte;
	logic byte_in;

	assign tx_byte = tx_sr[FB-1 -: WB]; // MSB first
	assign accept = (state == spi_link_pkg::s_idle) && frame_req && !frame_ack;
	assign byte_in = (state == spi_link_pkg::s_shift) && done;
	assign last_byte = byte_cnt == BCW'(spi_link_pkg::FRAME_BYTES - 1);

	// Frame shift registers
	always_ff @(posedge clk) begin
		if (accept) begin
			tx_sr <= tx_frame;
		end else if (byte_in) begin
			tx_sr <= tx_sr << WB;
		end
		if (byte_in) begin
			rx_frame <= {rx_frame[FB-WB-1:0], rx_byte};
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= spi_link_pkg::s_idle;
			frame_ack <= 1'b0;
			start <= 1'b0;
			rx_wr <= 1'b0;
			rx_overflow <= 1'b0;
			cs_n <= 1'b1;
			byte_cnt <= '0;
			gap_cnt <= '0;
		end else begin
			start <= 1'b0;
			rx_wr <= 1'b0;

			// Last phase of the handshake
			if (frame_ack && !frame_req) begin
				frame_ack <= 1'b0;
			end
			if (gap_cnt != '0) begin
				gap_cnt <= gap_cnt - 1'b1;
			end

			case (state)
				spi_link_pkg::s_idle: begin
					if (accept) begin
						frame_ack <= 1'b1;
						cs_n <= 1'b0;
						byte_cnt <= '0;
						state <= spi_link_pkg::s_fetch;
					end
				end
				spi_link_pkg::s_fetch: begin
					if (!busy) begin
						start <= 1'b1;
						state <= spi_link_pkg::s_shift;
					end
				end
				spi_link_pkg::s_shift: begin
					if (done) begin
						byte_cnt <= byte_cnt + 1'b1;
						if (last_byte) begin
							cs_n <= 1'b1; // Frame ends with the fourth byte
							gap_cnt <= GW'(GAP);
							state <= spi_link_pkg::s_store;
						end else begin
							state <= spi_link_pkg::s_fetch;
						end
					end
				end
				spi_link_pkg::s_store: begin
					if (rx_full) begin
						rx_overflow <= 1'b1; // Sticky until reset
					end else begin
						rx_wr <= 1'b1;
					end
					state <= spi_link_pkg::s_release;
				end
				spi_link_pkg::s_release: begin
					if (gap_cnt == '0) begin
						state <= spi_link_pkg::s_idle;
					end
				end
				default: state <= spi_link_pkg::s_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/spi_master.sv
`timescale 1ns/1ns
`default_nettype none

module spi_master #(
	parameter int CLK_DIV = 2
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,
	input  spi_link_pkg::spi_word_t tx_byte,
	output logic                    busy,
	output logic                    done,
	output spi_link_pkg::spi_word_t rx_byte,
	output logic                    sclk,
	output logic                    mosi,
	input  logic                    miso
);

	localparam int WB = $bits(spi_link_pkg::spi_word_t);
	localparam int DW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam int BW = $clog2(WB);

	logic [DW-1:0] div_cnt;
	logic [BW-1:0] bit_cnt; // Falling edges seen
	spi_link_pkg::spi_word_t sr;
	logic miso_q;
	logic tick; // End of a half SCLK period

	assign tick = div_cnt == DW'(CLK_DIV - 1);
	assign rx_byte = sr; // Holds received byte after done

	// Tx bits leave from the top and rx bits enter at the bottom
	always_ff @(posedge clk) begin
		if (!busy && start) begin
			sr <= tx_byte;
		end else if (busy && tick) begin
			if (!sclk) begin
				miso_q <= miso; // Rising edge sample
			end else begin
				sr <= {sr[WB-2:0], miso_q};
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			sclk <= 1'b0;
			mosi <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				if (start) begin
					busy <= 1'b1;
					mosi <= tx_byte[WB-1]; // Setup before first rise
					div_cnt <= '0;
					bit_cnt <= '0;
				end
			end else if (tick) begin
				div_cnt <= '0;
				sclk <= !sclk;
				if (sclk) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == BW'(WB - 1)) begin
						busy <= 1'b0;
						done <= 1'b1;
						mosi <= 1'b0;
					end else begin
						mosi <= sr[WB-2]; // Next bit on falling edge
					end
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/spi_link_top.sv
`timescale 1ns/1ns
`default_nettype none

module spi_link_top #(
	parameter int BUF_DEPTH = 8,
	parameter int CLK_DIV = 2
) (
	input  logic                      clk,
	input  logic                      rst,
	// Host transmit side
	input  logic                      wr,
	input  spi_link_pkg::frame_t      data_in,
	input  logic                      send,
	output spi_link_pkg::buf_flags_t  tx_flags,
	// Host receive side
	input  logic                      oe,
	output spi_link_pkg::frame_t      data_out,
	output spi_link_pkg::buf_flags_t  rx_flags,
	output logic                      rx_overflow,
	// SPI pins
	output logic                      sclk,
	output logic                      mosi,
	input  logic                      miso,
	output logic                      cs_n
);

	logic frame_req;
	logic frame_ack;
	spi_link_pkg::frame_t tx_frame;
	logic start;
	spi_link_pkg::spi_word_t tx_byte;
	logic busy;
	logic done;
	spi_link_pkg::spi_word_t rx_byte;
	logic rx_wr;
	spi_link_pkg::frame_t rx_frame;

	buffer_switch #(
		.BUF_DEPTH(BUF_DEPTH)
	) u_switch (
		.clk(clk),
		.rst(rst),
		.wr(wr),
		.data_in(data_in),
		.send(send),
		.tx_flags(tx_flags),
		.frame_req(frame_req),
		.frame_ack(frame_ack),
		.tx_frame(tx_frame)
	);

	frame_serdes #(
		.CLK_DIV(CLK_DIV)
	) u_serdes (
		.clk(clk),
		.rst(rst),
		.frame_req(frame_req),
		.frame_ack(frame_ack),
		.tx_frame(tx_frame),
		.start(start),
		.tx_byte(tx_byte),
		.busy(busy),
		.done(done),
		.rx_byte(rx_byte),
		.rx_wr(rx_wr),
		.rx_frame(rx_frame),
		.rx_full(rx_flags.full),
		.rx_overflow(rx_overflow),
		.cs_n(cs_n)
	);

	spi_master #(
		.CLK_DIV(CLK_DIV)
	) u_master (
		.clk(clk),
		.rst(rst),
		.start(start),
		.tx_byte(tx_byte),
		.busy(busy),
		.done(done),
		.rx_byte(rx_byte),
		.sclk(sclk),
		.mosi(mosi),
		.miso(miso)
	);

	// Receive side never needs a clear
	frame_buffer #(
		.BUF_DEPTH(BUF_DEPTH)
	) u_rx_buf (
		.clk(clk),
		.rst(rst),
		.clear(1'b0),
		.wr(rx_wr),
		.data_in(rx_frame),
		.oe(oe),
		.data_out(data_out),
		.flags(rx_flags)
	);

endmodule

`default_nettype wire

//--- bench/spi_slave_model.sv
`timescale 1ns/1ns
`default_nettype none

// Mode 0 SPI slave that answers each byte with the byte it received before
module spi_slave_model (
	input  logic                     rst,
	input  logic                     sclk,
	input  logic                     mosi,
	input  logic                     cs_n,
	output logic                     miso,
	output spi_link_pkg::spi_word_t  seen_byte, // Last complete byte from mosi
	output int unsigned              seen_count,
	output int unsigned              stray_edges
);

	localparam int WB = $bits(spi_link_pkg::spi_word_t);
	localparam int BW = $clog2(WB);

	spi_link_pkg::spi_word_t in_sr = '0;
	spi_link_pkg::spi_word_t out_sr = '0; // Zero until the first byte arrives
	logic [BW-1:0] bit_cnt = '0;
	int unsigned loaded_count = 0;

	assign miso = cs_n ? 1'b0 : out_sr[WB-1];

	// Capture on the rising edge, MSB first
	always @(posedge sclk or posedge rst) begin
		if (rst) begin
			in_sr <= '0;
			bit_cnt <= '0;
			seen_byte <= '0;
			seen_count <= 0;
			stray_edges <= 0;
		end else if (cs_n) begin
			stray_edges <= stray_edges + 1; // Clock without select
		end else begin
			in_sr <= {in_sr[WB-2:0], mosi};
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == BW'(WB - 1)) begin
				seen_byte <= {in_sr[WB-2:0], mosi};
				seen_count <= seen_count + 1;
			end
		end
	end

	// Falling edge shifts the reply, a finished byte becomes the next reply
	always @(negedge sclk or posedge rst) begin
		if (rst) begin
			out_sr <= '0;
			loaded_count <= 0;
		end else if (seen_count != loaded_count) begin
			out_sr <= seen_byte;
			loaded_count <= seen_count;
		end else begin
			out_sr <= out_sr << 1;
		end
	end

endmodule

`default_nettype wire

//--- bench/spi_link_tb.sv
`timescale 1ns/1ns
`default_nettype none

module spi_link_tb;

	localparam int BUF_DEPTH = 4;
	localparam int CLK_DIV = 2;
	localparam int FB = spi_link_pkg::FRAME_BYTES;
	localparam int TX_FRAMES = 12; // Frames that reach mosi over the run
	localparam int WATCHDOG_CYCLES = TX_FRAMES * 40 * 16 * CLK_DIV + 2000;

	logic clk;
	logic rst;
	logic wr;
	spi_link_pkg::frame_t data_in;
	logic send;
	spi_link_pkg::buf_flags_t tx_flags;
	logic oe;
	spi_link_pkg::frame_t data_out;
	spi_link_pkg::buf_flags_t rx_flags;
	logic rx_overflow;
	logic sclk;
	logic mosi;
	logic miso;
	logic cs_n;
	spi_link_pkg::spi_word_t seen_byte;
	int unsigned seen_count;
	int unsigned stray_edges;

	// Reference model
	spi_link_pkg::spi_word_t exp_mosi [$];
	spi_link_pkg::frame_t rx_exp [$];
	spi_link_pkg::spi_word_t prev_byte;
	int fill_cnt;
	int rx_wr_cnt;
	int rx_rd_cnt;
	int frames_sent;
	bit ovf_exp;

	int checks;
	int errors;
	int unsigned last_count;
	int unsigned cs_start;
	int cs_frames;
	logic cs_prev;
	spi_link_pkg::spi_word_t mon_byte;

	spi_link_top #(
		.BUF_DEPTH(BUF_DEPTH),
		.CLK_DIV(CLK_DIV)
	) dut0 (.*);

	spi_slave_model slave0 (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = !clk;
		end
	end

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("error %s exp 0x%0h got 0x%0h", name, exp, got);
		end
	endtask

	task automatic confirm(input bit ok, input string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("%s", what);
		end
	endtask

	// Flag rules in terms of writes and reads since the last clear
	function automatic spi_link_pkg::buf_flags_t expected_flags(input int wr_cnt, input int rd_cnt);
		spi_link_pkg::buf_flags_t f;
		f.has_data = rd_cnt < wr_cnt;
		f.empty = wr_cnt == 0;
		f.drained = (wr_cnt != 0) && (rd_cnt == wr_cnt);
		f.full = wr_cnt == BUF_DEPTH;
		return f;
	endfunction

	// Slave echo makes each received frame start with the last byte of the frame before
	function automatic void predict_frame(input spi_link_pkg::frame_t f);
		for (int i = FB - 1; i >= 0; i--) begin
			exp_mosi.push_back(f[i*8 +: 8]);
		end
		if (rx_wr_cnt < BUF_DEPTH) begin
			rx_exp.push_back({prev_byte, f[31:8]});
			rx_wr_cnt++;
		end else begin
			ovf_exp = 1'b1; // Receive buffer never clears
		end
		prev_byte = f[7:0];
		frames_sent++;
	endfunction

	task automatic write_frame(input spi_link_pkg::frame_t f);
		bit accepted;
		accepted = fill_cnt < BUF_DEPTH;
		if (accepted) begin
			predict_frame(f);
			fill_cnt++;
		end
		wr = 1'b1;
		data_in = f;
		step();
		wr = 1'b0;
		if (accepted) begin
			compare("tx_flags", {28'd0, expected_flags(fill_cnt, 0)}, {28'd0, tx_flags});
		end
	endtask

	task automatic pulse_send();
		send = 1'b1;
		step();
		send = 1'b0;
		fill_cnt = 0; // Batch now belongs to the drain side
	endtask

	task automatic wait_idle();
		while (exp_mosi.size() != 0) begin
			step();
		end
		while (!cs_n) begin
			step();
		end
		repeat (2 * CLK_DIV + 2) begin
			step(); // Gap plus the receive write
		end
	endtask

	task automatic drain_rx();
		spi_link_pkg::frame_t exp;
		while (rx_rd_cnt < rx_wr_cnt) begin
			exp = rx_exp.pop_front();
			oe = 1'b1;
			step();
			oe = 1'b0;
			rx_rd_cnt++;
			compare("data_out", exp, data_out);
			compare("rx_flags", {28'd0, expected_flags(rx_wr_cnt, rx_rd_cnt)}, {28'd0, rx_flags});
		end
		compare("rx_flags", {28'd0, expected_flags(rx_wr_cnt, rx_rd_cnt)}, {28'd0, rx_flags});
		compare("rx_overflow", {31'd0, ovf_exp}, {31'd0, rx_overflow});
	endtask

	// Bytes seen by the slave against the sent order
	always @(negedge clk) begin
		if (seen_count != last_count) begin
			last_count = seen_count;
			if (exp_mosi.size() == 0) begin
				confirm(1'b0, "byte on mosi with no frame pending");
			end else begin
				mon_byte = exp_mosi.pop_front();
				compare("mosi_byte", {24'd0, mon_byte}, {24'd0, seen_byte});
			end
		end
	end

	// One select window per frame
	always @(negedge clk) begin
		if (!rst) begin
			if (cs_prev && !cs_n) begin
				cs_start = seen_count;
			end
			if (!cs_prev && cs_n) begin
				cs_frames++;
				confirm(seen_count - cs_start == FB, "cs_n low for other than four bytes");
			end
			cs_prev = cs_n;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) begin
			@(posedge clk);
		end
		$display("timeout after %0d cycles, the transfers never finished", WATCHDOG_CYCLES);
		$display("checks %0d errors %0d", checks, errors);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h5107ffd2));
		rst = 1'b1;
		wr = 1'b0;
		data_in = '0;
		send = 1'b0;
		oe = 1'b0;
		prev_byte = '0; // Slave answers 0 first
		fill_cnt = 0;
		rx_wr_cnt = 0;
		rx_rd_cnt = 0;
		frames_sent = 0;
		ovf_exp = 1'b0;
		checks = 0;
		errors = 0;
		last_count = 0;
		cs_start = 0;
		cs_frames = 0;
		cs_prev = 1'b1;
		repeat (4) begin
			@(posedge clk);
		end
		#1;
		rst = 1'b0;

		compare("tx_flags", {28'd0, expected_flags(0, 0)}, {28'd0, tx_flags});
		compare("rx_flags", {28'd0, expected_flags(0, 0)}, {28'd0, rx_flags});
		compare("cs_n", 32'd1, {31'd0, cs_n});
		compare("rx_overflow", 32'd0, {31'd0, rx_overflow});

		// Two frames and a send
		repeat (2) begin
			write_frame($urandom());
		end
		pulse_send();
		compare("tx_flags", {28'd0, expected_flags(0, 0)}, {28'd0, tx_flags});
		wait_idle();
		drain_rx();

		// Full buffer leaves without send and drops the extra write
		repeat (BUF_DEPTH + 1) begin
			write_frame($urandom());
		end
		compare("tx_flags", {28'd0, expected_flags(0, 0)}, {28'd0, tx_flags});
		fill_cnt = 0;
		wait_idle();
		drain_rx();

		// Ping-pong with the second batch written while the first shifts
		repeat (3) begin
			write_frame($urandom());
		end
		pulse_send();
		while (cs_n) begin
			step();
		end
		repeat (3) begin
			write_frame($urandom());
		end
		pulse_send();
		compare("tx_flags", {28'd0, expected_flags(3, 0)}, {28'd0, tx_flags}); // Send held
		wait_idle();
		compare("tx_flags", {28'd0, expected_flags(0, 0)}, {28'd0, tx_flags});
		drain_rx();

		confirm(stray_edges == 0, "sclk toggled while cs_n was high");
		compare("cs_frames", 32'(frames_sent), 32'(cs_frames));
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- spi_link_top.f
logic/spi_link_pkg.sv
logic/frame_buffer.sv
logic/buffer_switch.sv
logic/frame_serdes.sv
logic/spi_master.sv
logic/spi_link_top.sv
bench/spi_slave_model.sv
bench/spi_link_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP = spi_link_tb
FILELIST = spi_link_top.f

BUILD_DIR = obj_dir
SIM = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))
PASS_TEXT = TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Status comes from the pass line in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
